// File: Bender.yml
package:
  name: fetch_stage

sources:
  - hw/fetchPkg.sv
  - hw/pcUnit.sv
  - hw/instrCache.sv
  - hw/hazardDetect.sv
  - hw/fetchStage.sv
  - target: test
    files:
      - tb/fetchClock.sv
      - tb/fetchStage_props.sv
      - tb/fetchTb.sv

// File: files.f
hw/fetchPkg.sv
hw/pcUnit.sv
hw/instrCache.sv
hw/hazardDetect.sv
hw/fetchStage.sv
tb/fetchClock.sv
tb/fetchStage_props.sv
tb/fetchTb.sv

// File: hw/fetchPkg.sv
// fetch stage package: widths, cache geometry, instruction fields and shared types
package fetchPkg;

   // datapath widths
   localparam int addrWidth   = 16;
   localparam int instrWidth  = 16;
   localparam int regIdxWidth = 3;
   localparam int opWidth     = 5;

   // pc steps by one 16-bit word, extra bit catches the carry out
   localparam logic [addrWidth:0] pcStep = (addrWidth + 1)'(2);

   // direct-mapped cache, one word per line
   localparam int cacheLines = 16;
   localparam int idxWidth   = $clog2(cacheLines);
   localparam int idxLo      = 1;
   localparam int idxHi      = idxLo + idxWidth - 1;
   localparam int tagLo      = idxHi + 1;
   localparam int tagHi      = addrWidth - 1;
   localparam int tagWidth   = tagHi - tagLo + 1;

   // instruction field positions
   localparam int opHi = 15;
   localparam int opLo = 11;
   localparam int rsHi = 10;
   localparam int rsLo = 8;
   localparam int rtHi = 7;
   localparam int rtLo = 5;

   // major opcodes, halt and nop read no registers
   typedef enum logic [opWidth-1:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opAddi  = 5'b01000,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opStore = 5'b10000,
      opLoad  = 5'b10001,
      opAdd   = 5'b11011
   } opcodeT;

   localparam logic [instrWidth-1:0] nopInstr = {opNop, {(instrWidth - opWidth){1'b0}}};

   // operand forwarding source, youngest writer first
   typedef enum logic [1:0] {fwdNone, fwdX, fwdM, fwdW} fwdSelT;

   // write-back source, wbMem marks a load
   typedef enum logic [1:0] {wbAlu, wbMem, wbPc} wbSelT;

   // register write info of one later pipeline stage
   typedef struct packed {
      logic                   regWrt;
      logic [regIdxWidth-1:0] wrtReg;
      wbSelT                  wbSel;
   } stageWrT;

   // four-phase memory port
   typedef struct packed {
      logic                 req;
      logic [addrWidth-1:0] addr;
   } memReqT;

   typedef struct packed {
      logic                  ack;
      logic [instrWidth-1:0] data;
   } memRspT;

   // decode-side output bundle
   typedef struct packed {
      logic                  valid;
      logic [instrWidth-1:0] instr;
      logic [addrWidth-1:0]  pcNext;
      fwdSelT                fwdA;
      fwdSelT                fwdB;
   } fetchOutT;

endpackage

// File: hw/fetchStage.sv
// instruction fetch stage top: pc, instruction cache and hazard unit with stall and error logic
`timescale 1ns/1ps
module fetchStage (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          redirect,
   input  logic [fetchPkg::addrWidth-1:0] newPc,
   input  logic                          decodeStall,
   input  fetchPkg::stageWrT             wrD,
   input  fetchPkg::stageWrT             wrX,
   input  fetchPkg::stageWrT             wrM,
   input  fetchPkg::stageWrT             wrW,
   output fetchPkg::memReqT              memReq,
   input  fetchPkg::memRspT              memRsp,
   output fetchPkg::fetchOutT            fetchOut,
   output logic                          fetchStall,
   output logic                          err
);
   import fetchPkg::*;

   logic [addrWidth-1:0]  pc;
   logic [addrWidth-1:0]  pcNext;
   logic [instrWidth-1:0] instr;
   logic                  hit;
   logic                  missBusy;
   logic                  loadUseHold;
   logic                  pcErr;
   logic                  advance;
   logic                  fetchValid;

   // pc moves only when the word at pc is usable and nothing downstream holds it
   assign advance = ~(decodeStall | missBusy | ~hit | loadUseHold | pcErr);

   // a hit counts only outside a fill and before any error
   assign fetchValid = hit & ~missBusy & ~pcErr;

   assign fetchStall = missBusy;
   assign err        = pcErr;

   pcUnit pc0 (
      .clk      (clk),
      .reset    (reset),
      .advance  (advance),
      .redirect (redirect),
      .newPc    (newPc),
      .pc       (pc),
      .pcNext   (pcNext),
      .err      (pcErr)
   );

   instrCache ic0 (
      .clk      (clk),
      .reset    (reset),
      .pc       (pc),
      .instr    (instr),
      .hit      (hit),
      .missBusy (missBusy),
      .memReq   (memReq),
      .memRsp   (memRsp)
   );

   // registers the word for decode and computes hold and forwarding
   hazardDetect hz0 (
      .clk         (clk),
      .reset       (reset),
      .fetchInstr  (instr),
      .fetchValid  (fetchValid),
      .pcNext      (pcNext),
      .redirect    (redirect),
      .decodeStall (decodeStall),
      .wrD         (wrD),
      .wrX         (wrX),
      .wrM         (wrM),
      .wrW         (wrW),
      .loadUseHold (loadUseHold),
      .fetchOut    (fetchOut)
   );

endmodule

// File: hw/hazardDetect.sv
// fetch-to-decode register with NOP insertion, load-use hold and forwarding selects
`timescale 1ns/1ps
module hazardDetect (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [fetchPkg::instrWidth-1:0] fetchInstr,
   input  logic                           fetchValid,
   input  logic [fetchPkg::addrWidth-1:0]  pcNext,
   input  logic                           redirect,
   input  logic                           decodeStall,
   input  fetchPkg::stageWrT              wrD,
   input  fetchPkg::stageWrT              wrX,
   input  fetchPkg::stageWrT              wrM,
   input  fetchPkg::stageWrT              wrW,
   output logic                           loadUseHold,
   output fetchPkg::fetchOutT             fetchOut
);
   import fetchPkg::*;

   opcodeT                 op;
   logic [regIdxWidth-1:0] rs;
   logic [regIdxWidth-1:0] rt;
   logic                   readsSrc;
   logic                   dIsLoad;
   logic                   kill;
   fwdSelT                 selA;
   fwdSelT                 selB;
   fetchOutT               outNext;

   // pick the youngest stage that writes src
   // index matches with regWrt low do not count
   function automatic fwdSelT pickFwd(
      input logic [regIdxWidth-1:0] src,
      input stageWrT                x,
      input stageWrT                m,
      input stageWrT                w
   );
      fwdSelT sel;
      sel = fwdNone;
      if (x.regWrt && x.wrtReg == src) begin
         sel = fwdX;
      end else if (m.regWrt && m.wrtReg == src) begin
         sel = fwdM;
      end else if (w.regWrt && w.wrtReg == src) begin
         sel = fwdW;
      end
      return sel;
   endfunction

   // decode just enough of the fetched word
   assign op = opcodeT'(fetchInstr[opHi:opLo]);
   assign rs = fetchInstr[rsHi:rsLo];
   assign rt = fetchInstr[rtHi:rtLo];

   // everything but halt and nop reads rs and rt
   assign readsSrc = (op != opHalt) && (op != opNop);

   // load sitting in decode whose result the fetched word needs
   assign dIsLoad     = wrD.regWrt && (wrD.wbSel == wbMem);
   assign loadUseHold = fetchValid && readsSrc && dIsLoad &&
                        ((wrD.wrtReg == rs) || (wrD.wrtReg == rt));

   assign selA = readsSrc ? pickFwd(rs, wrX, wrM, wrW) : fwdNone;
   assign selB = readsSrc ? pickFwd(rt, wrX, wrM, wrW) : fwdNone;

   // miss, redirect and load-use all turn the slot into a bubble
   assign kill = !fetchValid || redirect || loadUseHold;

   always_comb begin
      outNext.pcNext = pcNext;
      if (kill) begin
         outNext.valid = 1'b0;
         outNext.instr = nopInstr;
         outNext.fwdA  = fwdNone;
         outNext.fwdB  = fwdNone;
      end else begin
         outNext.valid = 1'b1;
         outNext.instr = fetchInstr;
         outNext.fwdA  = selA;
         outNext.fwdB  = selB;
      end
   end

   // decode register, frozen while decode pushes back
   always_ff @(posedge clk) begin
      if (reset) begin
         fetchOut.valid  <= 1'b0;
         fetchOut.instr  <= nopInstr;
         fetchOut.pcNext <= '0;
         fetchOut.fwdA   <= fwdNone;
         fetchOut.fwdB   <= fwdNone;
      end else if (!decodeStall) begin
         fetchOut <= outNext;
      end
   end

endmodule

// File: hw/instrCache.sv
// direct-mapped read-only instruction cache, fills one word per miss over four-phase req/ack
`timescale 1ns/1ps
module instrCache (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [fetchPkg::addrWidth-1:0]  pc,
   output logic [fetchPkg::instrWidth-1:0] instr,
   output logic                           hit,
   output logic                           missBusy,
   output fetchPkg::memReqT               memReq,
   input  fetchPkg::memRspT               memRsp
);
   import fetchPkg::*;

   // miss engine states
   typedef enum logic [1:0] {idle, request, waitAckLow} missStateT;

   missStateT state;

   // line storage
   logic [cacheLines-1:0] validArr;
   logic [tagWidth-1:0]   tagArr [cacheLines];
   logic [instrWidth-1:0] dataArr [cacheLines];

   // lookup fields of the current pc
   logic [idxWidth-1:0] pcIdx;
   logic [tagWidth-1:0] pcTag;

   // address of the line being filled
   logic [addrWidth-1:0] fillAddr;
   logic [idxWidth-1:0]  fillIdx;
   logic [tagWidth-1:0]  fillTag;

   // fill data is taken on the cycle ack is seen during request
   logic fillCapture;

   assign pcIdx   = pc[idxHi:idxLo];
   assign pcTag   = pc[tagHi:tagLo];
   assign fillIdx = fillAddr[idxHi:idxLo];
   assign fillTag = fillAddr[tagHi:tagLo];

   assign fillCapture = (state == request) && memRsp.ack;

   // lookup is purely combinational, hit and data in the same cycle as pc
   assign hit   = validArr[pcIdx] && (tagArr[pcIdx] == pcTag);
   assign instr = dataArr[pcIdx];

   // busy only while the request phase is open
   // after capture the line is valid so the access hits
   assign missBusy = (state == request);

   // req follows the state, addr is the latched miss address
   always_comb begin
      memReq.req  = (state == request);
      memReq.addr = fillAddr;
   end

   // miss state machine
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= idle;
      end else begin
         case (state)
            idle: begin
               // only start a new request once ack is low
               if (!hit && !memRsp.ack) begin
                  state <= request;
               end
            end
            request: begin
               // memory has data, capture and drop req
               if (memRsp.ack) begin
                  state <= waitAckLow;
               end
            end
            waitAckLow: begin
               // last phase, memory releases ack
               if (!memRsp.ack) begin
                  state <= idle;
               end
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // miss address, latched as the request opens
   always_ff @(posedge clk) begin
      if (state == idle && !hit && !memRsp.ack) begin
         fillAddr <= pc;
      end
   end

   // valid bits are control state and clear on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         validArr <= '0;
      end else if (fillCapture) begin
         validArr[fillIdx] <= 1'b1;
      end
   end

   // tag and data arrays, written only by the fill
   always_ff @(posedge clk) begin
      if (fillCapture) begin
         tagArr[fillIdx]  <= fillTag;
         dataArr[fillIdx] <= memRsp.data;
      end
   end

endmodule

// File: hw/pcUnit.sv
// program counter with +2 incrementer, redirect select and sticky address error
`timescale 1ns/1ps
module pcUnit (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          advance,
   input  logic                          redirect,
   input  logic [fetchPkg::addrWidth-1:0] newPc,
   output logic [fetchPkg::addrWidth-1:0] pc,
   output logic [fetchPkg::addrWidth-1:0] pcNext,
   output logic                          err
);
   import fetchPkg::*;

   logic [addrWidth-1:0] pcReg;
   // one extra bit so the carry out of the increment is visible
   logic [addrWidth:0]   incSum;
   logic                 errSticky;
   logic                 curErr;

   assign incSum = {1'b0, pcReg} + pcStep;

   // odd pc is unaligned, carry means the pc wrapped past the top
   assign curErr = pcReg[0] | incSum[addrWidth];

   // flag raised in the same cycle the bad pc shows up
   assign err = errSticky | curErr;

   always_ff @(posedge clk) begin
      if (reset) begin
         pcReg     <= '0;
         errSticky <= 1'b0;
      end else begin
         errSticky <= errSticky | curErr;
         // once in error the pc freezes until reset
         if (!err) begin
            // redirect wins over a held pc
            if (redirect) begin
               pcReg <= newPc;
            end else if (advance) begin
               pcReg <= incSum[addrWidth-1:0];
            end
         end
      end
   end

   assign pc     = pcReg;
   assign pcNext = incSum[addrWidth-1:0];

endmodule

// File: tb/fetchClock.sv
// testbench clock and reset source, 4 ns clock with reset held for five cycles
`timescale 1ns/1ps
module fetchClock (
   output logic clk,
   output logic reset
);
   initial begin
      clk   = 1'b0;
      reset = 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
   end

   always #2 clk = ~clk;

endmodule

// File: tb/fetchStage_props.sv
// concurrent checks on the memory handshake and the decode-side register of the fetch stage
`timescale 1ns/1ps
module fetchStageProps (
   input logic                clk,
   input logic                reset,
   input logic                decodeStall,
   input fetchPkg::memReqT    memReq,
   input fetchPkg::memRspT    memRsp,
   input fetchPkg::fetchOutT  fetchOut
);
   import fetchPkg::*;

   // req is held until the memory answers
   reqHeld: assert property (@(posedge clk) disable iff (reset)
      (memReq.req && !memRsp.ack) |=> memReq.req)
      else $error("req dropped before ack");

   // address must not move during an open request
   addrStable: assert property (@(posedge clk) disable iff (reset)
      (memReq.req && $past(memReq.req)) |-> $stable(memReq.addr))
      else $error("addr changed while req high");

   // new request only after the previous ack is gone
   noReqOnAck: assert property (@(posedge clk) disable iff (reset)
      $rose(memReq.req) |-> !memRsp.ack)
      else $error("req raised while ack high");

   // decode register frozen by back-pressure
   outHeld: assert property (@(posedge clk) disable iff (reset)
      decodeStall |=> $stable(fetchOut))
      else $error("fetchOut changed under decodeStall");

endmodule

bind fetchStage fetchStageProps props0 (
   .clk         (clk),
   .reset       (reset),
   .decodeStall (decodeStall),
   .memReq      (memReq),
   .memRsp      (memRsp),
   .fetchOut    (fetchOut)
);

// File: tb/fetchTb.sv
// fetch stage testbench with memory model, reference functions and in-order compare
`timescale 1ns/1ps
module fetchTb;
   import fetchPkg::*;

   logic clk, reset, redirect, decodeStall, reqPrev, updated, sReset, errMode;
   logic [15:0] newPc, expPc, expIns;
   logic [3:0] expSel;
   stageWrT wrD, wrX, wrM, wrW, sWrD, sWrX, sWrM, sWrW;
   memReqT memReq;
   memRspT memRsp;
   fetchOutT fetchOut, prevOut;
   logic fetchStall, err;
   int cycle, delivered, lastDelivCycle, reqCnt, memState, memCnt, c0, r0;

   fetchClock clk0 (.clk(clk), .reset(reset));

   fetchStage dut0 (.clk(clk), .reset(reset), .redirect(redirect), .newPc(newPc),
      .decodeStall(decodeStall), .wrD(wrD), .wrX(wrX), .wrM(wrM), .wrW(wrW),
      .memReq(memReq), .memRsp(memRsp), .fetchOut(fetchOut), .fetchStall(fetchStall),
      .err(err));

   // fixed hash of the address that never yields a halt opcode
   function automatic logic [15:0] memWord(input logic [15:0] a);
      logic [15:0] h;
      opcodeT op;
      h = a * 16'h9e37 + 16'h3c5a;
      h = h ^ (h >> 7);
      case (h[15:13])
         3'd0: op = opNop;
         3'd1: op = opJ;
         3'd2: op = opAddi;
         3'd3: op = opBeqz;
         3'd4: op = opBnez;
         3'd5: op = opStore;
         3'd6: op = opLoad;
         default: op = opAdd;
      endcase
      return {op, h[10:0]};
   endfunction

   // youngest writer wins and opcodes 0 and 1 read nothing
   function automatic logic [3:0] expectFwd(input logic [15:0] ins,
         input stageWrT x, input stageWrT m, input stageWrT w);
      logic [1:0] sel [2];
      logic [2:0] src;
      for (int i = 0; i < 2; i++) begin
         src = (i == 0) ? ins[10:8] : ins[7:5];
         sel[i] = 2'd0;
         if (ins[15:12] != 4'd0) begin
            if (x.regWrt && x.wrtReg == src) sel[i] = 2'd1;
            else if (m.regWrt && m.wrtReg == src) sel[i] = 2'd2;
            else if (w.regWrt && w.wrtReg == src) sel[i] = 2'd3;
         end
      end
      return {sel[0], sel[1]};
   endfunction

   // load in decode that writes a source of the fetched word
   function automatic logic loadUses(input logic [15:0] ins, input stageWrT d);
      return (ins[15:12] != 4'd0) && d.regWrt && (d.wbSel == wbMem) &&
             (d.wrtReg == ins[10:8] || d.wrtReg == ins[7:5]);
   endfunction

   function automatic stageWrT randWr();
      stageWrT w;
      w.regWrt = 1'($urandom % 2);
      w.wrtReg = 3'($urandom % 8);
      w.wbSel  = wbSelT'($urandom % 3);
      return w;
   endfunction

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
         failRun("value mismatch");
      end
   endtask

   task automatic waitDelivered(input int n);
      int target;
      int t;
      target = delivered + n;
      t = 0;
      while (delivered < target) begin
         @(posedge clk);
         t++;
         if (t > 300) failRun("timed out waiting for fetched instructions");
      end
   endtask

   // one-cycle redirect pulse from execute
   task automatic pulseRedirect(input logic [15:0] pc);
      @(posedge clk);
      redirect <= 1'b1;
      newPc    <= pc;
      @(posedge clk);
      redirect <= 1'b0;
   endtask

   // memory model acks after 1 to 6 cycles and drops ack once req falls
   always @(posedge clk) begin
      if (reset) begin
         memState <= 0;
         memRsp   <= '0;
      end else if (memState == 0 && memReq.req && !memRsp.ack) begin
         memCnt   <= $urandom % 6 + 1;
         memState <= 1;
      end else if (memState == 1) begin
         memCnt <= memCnt - 1;
         if (memCnt == 1) begin
            memRsp.ack  <= 1'b1;
            memRsp.data <= memWord(memReq.addr);
            memState    <= 2;
         end
      end else if (memState == 2 && !memReq.req) begin
         memRsp.ack <= 1'b0;
         memState   <= 0;
      end
   end

   // sample what the DUT used at this edge
   always @(posedge clk) begin
      cycle   <= cycle + 1;
      sReset  <= reset;
      updated <= !reset && !decodeStall;
      sWrD <= wrD;
      sWrX <= wrX;
      sWrM <= wrM;
      sWrW <= wrW;
      // a taken redirect restarts the expected pc sequence
      if (!reset && redirect) begin
         expPc   = newPc;
         errMode <= errMode | newPc[0];
      end
      // count rising edges of req
      if (memReq.req && !reqPrev) reqCnt <= reqCnt + 1;
      reqPrev <= memReq.req;
   end

   // compare every delivered instruction against the expected pc sequence
   always @(negedge clk) begin
      // stall flag spans the open fill, err follows the odd redirect
      if (!sReset) begin
         checkEq("fetchStall", fetchStall, memReq.req);
         checkEq("err", err, errMode);
      end
      if (sReset) begin
         prevOut = fetchOut;
      end else if (updated) begin
         if (fetchOut.valid) begin
            if (errMode) failRun("valid instruction delivered after address error");
            expIns = memWord(expPc);
            expSel = expectFwd(expIns, sWrX, sWrM, sWrW);
            if (loadUses(expIns, sWrD)) failRun("instruction passed a load-use hazard");
            checkEq("fetchOut.instr", fetchOut.instr, expIns);
            checkEq("fetchOut.pcNext", fetchOut.pcNext, expPc + 16'd2);
            checkEq("fetchOut.fwdA", fetchOut.fwdA, expSel[3:2]);
            checkEq("fetchOut.fwdB", fetchOut.fwdB, expSel[1:0]);
            expPc = expPc + 16'd2;
            delivered = delivered + 1;
            lastDelivCycle = cycle;
         end
         prevOut = fetchOut;
      end else begin
         checkEq("fetchOut under stall", fetchOut, prevOut);
      end
   end

   initial begin
      repeat (20000) @(posedge clk);
      failRun("simulation watchdog expired");
   end

   initial begin
      int t;
      void'($urandom(45));
      {cycle, delivered, lastDelivCycle, reqCnt} = '0;
      expPc = '0;
      errMode = 1'b0;
      reqPrev = 1'b0;
      redirect <= 1'b0;
      newPc <= '0;
      decodeStall <= 1'b0;
      memRsp <= '0;
      {wrD, wrX, wrM, wrW} <= '0;
      t = 0;
      while (reset) begin
         @(posedge clk);
         t++;
         if (t > 20) failRun("reset never released");
      end
      // cold misses through the first lines and then a loop back that must hit
      waitDelivered(15);
      pulseRedirect(16'h0000);
      waitDelivered(1);
      c0 = lastDelivCycle;
      r0 = reqCnt;
      waitDelivered(15);
      checkEq("hit loop cycles", lastDelivCycle - c0, 15);
      checkEq("memReq count", reqCnt, r0);
      // random even redirect targets
      repeat (4) begin
         pulseRedirect(16'($urandom) & 16'h7ffe);
         waitDelivered(6);
      end
      // random writers in D, X, M and W
      repeat (60) begin
         @(posedge clk);
         wrD <= randWr();
         wrX <= randWr();
         wrM <= randWr();
         wrW <= randWr();
      end
      @(posedge clk);
      {wrD, wrX, wrM, wrW} <= '0;
      waitDelivered(4);
      // back-pressure from decode
      repeat (60) begin
         @(posedge clk);
         decodeStall <= ($urandom % 3 == 0);
      end
      @(posedge clk);
      decodeStall <= 1'b0;
      waitDelivered(4);
      // odd target must raise a sticky error
      pulseRedirect(16'h0101);
      t = 0;
      while (!err) begin
         @(posedge clk);
         t++;
         if (t > 20) failRun("err did not rise after odd redirect");
      end
      repeat (30) @(posedge clk);
      checkEq("err", err, 1);
      $display("TEST OK");
      $finish;
   end

endmodule
